//--- design/mmctl_params.svh
// Build-time parameters of the matrix-multiply control unit
// Array height, bus and count widths
// Register map of the peripheral port

`ifndef MMCTL_PARAMS_SVH
`define MMCTL_PARAMS_SVH

// Rows of the processing array
`define MMCTL_HEIGHT 4

`define MMCTL_DATA_W 32
`define MMCTL_ADDR_W 8
`define MMCTL_CNT_W 16

// Register addresses
`define MMCTL_REG_TRIGGER 8'h00
`define MMCTL_REG_CLEAR   8'h04
`define MMCTL_REG_STATUS  8'h08
`define MMCTL_REG_ROWS    8'h0C
`define MMCTL_REG_STORES  8'h10

`endif

//--- design/mmctl_pkg.sv
// Shared types of the matrix-multiply control unit
// Job state encoding, bus word and address, job counters

`include "mmctl_params.svh"

package mmctl_pkg;

  // Job state of the control FSM
  typedef enum logic [2:0] {
    IDLE,
    STARTING,
    COMPUTING,
    BUFFERING,
    STORING,
    FINISHED
  } ctrl_state_e;

  typedef logic [`MMCTL_DATA_W-1:0] bus_data_t;
  typedef logic [`MMCTL_ADDR_W-1:0] bus_addr_t;

  // Row and store-phase counts
  typedef logic [`MMCTL_CNT_W-1:0] job_cnt_t;

  // Weights computed by the last PE of a row
  typedef logic [4:0] wcomp_cnt_t;

endpackage

//--- design/mmctl_regfile.sv
// Peripheral register slave of the control unit
// Job parameters, trigger and soft-clear pulses, busy status
// and the registered done event

`include "mmctl_params.svh"

module mmctl_regfile
  import mmctl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      periph_req_i,
  input  bus_addr_t periph_add_i,
  input  logic      periph_wen_i,
  input  bus_data_t periph_data_i,
  output logic      periph_gnt_o,
  output bus_data_t periph_r_data_o,
  output logic      periph_r_valid_o,
  input  logic      busy_i,
  input  logic      done_i,
  output logic      job_start_o,
  output logic      clear_o,
  output job_cnt_t  rows_per_tile_o,
  output job_cnt_t  total_stores_o,
  output logic      done_evt_o
);

  logic      wr_en;
  logic      rd_en;
  logic      job_start_q;
  logic      clear_q;
  logic      done_evt_q;
  logic      r_valid_q;
  bus_data_t r_data_q;
  bus_data_t rd_mux;
  job_cnt_t  rows_q;
  job_cnt_t  stores_q;

  // No wait states on this port
  assign periph_gnt_o = periph_req_i;
  assign wr_en = periph_req_i & ~periph_wen_i;
  assign rd_en = periph_req_i & periph_wen_i;

  always_comb begin
    rd_mux = '0;
    case (periph_add_i)
      `MMCTL_REG_STATUS: rd_mux[0] = busy_i;
      `MMCTL_REG_ROWS:   rd_mux[`MMCTL_CNT_W-1:0] = rows_q;
      `MMCTL_REG_STORES: rd_mux[`MMCTL_CNT_W-1:0] = stores_q;
      default:           rd_mux = '0;
    endcase
  end

  // Job parameters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rows_q   <= '0;
      stores_q <= '0;
    end else if (wr_en) begin
      if (periph_add_i == `MMCTL_REG_ROWS) begin
        rows_q <= periph_data_i[`MMCTL_CNT_W-1:0];
      end
      if (periph_add_i == `MMCTL_REG_STORES) begin
        stores_q <= periph_data_i[`MMCTL_CNT_W-1:0];
      end
    end
  end

  // Command pulses, read valid and done event
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      job_start_q <= 1'b0;
      clear_q     <= 1'b0;
      done_evt_q  <= 1'b0;
      r_valid_q   <= 1'b0;
    end else begin
      job_start_q <= wr_en && (periph_add_i == `MMCTL_REG_TRIGGER) && !clear_q;
      clear_q     <= wr_en && (periph_add_i == `MMCTL_REG_CLEAR);
      // A job cut short by a clear raises no event
      done_evt_q  <= done_i && !clear_q;
      r_valid_q   <= rd_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      r_data_q <= rd_mux;
    end
  end

  assign periph_r_data_o  = r_data_q;
  assign periph_r_valid_o = r_valid_q;
  assign job_start_o      = job_start_q;
  assign clear_o          = clear_q;
  assign rows_per_tile_o  = rows_q;
  assign total_stores_o   = stores_q;
  assign done_evt_o       = done_evt_q;

  // Each read response answers a read granted one cycle earlier
  a_rvalid_after_grant : assert property (@(posedge clk_i) disable iff (!rst_ni)
    periph_r_valid_o |-> $past(periph_req_i && periph_gnt_o && periph_wen_i));

endmodule

//--- design/weight_row_tracker.sv
// Weight-row tracking for the systolic array
// Loaded-row count, computed-weight count, last-row flag,
// column-complete and tile-drain events

`include "mmctl_params.svh"

module weight_row_tracker
  import mmctl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  ctrl_state_e state_i,
  input  logic        w_loaded_i,
  input  logic        reg_enable_i,
  input  job_cnt_t    rows_per_tile_i,
  output logic        w_tile_o,
  output logic        tile_drained_o
);

  job_cnt_t   row_cnt_q;
  job_cnt_t   row_cnt_d;
  wcomp_cnt_t w_comp_q;
  logic       count_w_q;
  logic       last_row_q;
  logic       in_compute;
  logic       cnt_clr;
  logic       rows_ready;
  logic       comp_rst;

  assign in_compute = (state_i == COMPUTING);
  assign cnt_clr    = clear_i || (state_i == IDLE) || (state_i == FINISHED);

  // Enough rows in the array to start counting computed weights
  assign rows_ready = (row_cnt_q >= job_cnt_t'(`MMCTL_HEIGHT)) ||
                      (row_cnt_q >= rows_per_tile_i);

  assign w_tile_o = in_compute && !last_row_q &&
                    (w_comp_q == wcomp_cnt_t'(`MMCTL_HEIGHT - 1));
  // Last row drains two weights early, the pipeline covers the rest
  assign tile_drained_o = in_compute && last_row_q && reg_enable_i &&
                          (w_comp_q == wcomp_cnt_t'(`MMCTL_HEIGHT - 2));
  assign comp_rst = w_tile_o || tile_drained_o;

  always_comb begin
    row_cnt_d = row_cnt_q;
    if (tile_drained_o) begin
      // Next tile already has its first row in flight
      row_cnt_d = job_cnt_t'(1);
    end else if (w_loaded_i) begin
      row_cnt_d = row_cnt_q + job_cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_cnt_q  <= '0;
      w_comp_q   <= '0;
      count_w_q  <= 1'b0;
      last_row_q <= 1'b0;
    end else if (cnt_clr) begin
      row_cnt_q  <= '0;
      w_comp_q   <= '0;
      count_w_q  <= 1'b0;
      last_row_q <= 1'b0;
    end else begin
      row_cnt_q <= row_cnt_d;
      if (comp_rst) begin
        w_comp_q  <= '0;
        count_w_q <= 1'b0;
      end else begin
        if (count_w_q && reg_enable_i) begin
          w_comp_q <= w_comp_q + wcomp_cnt_t'(1);
        end
        if (in_compute && rows_ready) begin
          count_w_q <= 1'b1;
        end
      end
      if (state_i == BUFFERING) begin
        last_row_q <= 1'b0;
      end else if (in_compute && (row_cnt_q >= rows_per_tile_i)) begin
        last_row_q <= 1'b1;
      end
    end
  end

endmodule

//--- design/accumulate_gen.sv
// Accumulate control for the engine
// Set/clear flag with a mask over pipeline stalls

module accumulate_gen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic reg_enable_i,
  input  logic set_i,
  input  logic clr_i,
  output logic accumulate_o
);

  logic acc_q;
  logic stall_mask_q;

  // Clear wins over set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= 1'b0;
    end else if (clear_i || clr_i) begin
      acc_q <= 1'b0;
    end else if (set_i) begin
      acc_q <= 1'b1;
    end
  end

  // Hide a flag that rises while the pipeline is stalled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_mask_q <= 1'b0;
    end else if (clear_i || reg_enable_i) begin
      stall_mask_q <= 1'b0;
    end else if (!acc_q) begin
      stall_mask_q <= 1'b1;
    end
  end

  assign accumulate_o = acc_q & ~stall_mask_q;

endmodule

//--- design/store_phase_counter.sv
// Store-phase counter
// Counts emptied output buffers against the programmed total

module store_phase_counter
  import mmctl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  ctrl_state_e state_i,
  input  logic        z_empty_i,
  input  job_cnt_t    total_stores_i,
  output logic        store_step_o,
  output logic        last_store_o
);

  job_cnt_t cnt_q;
  logic     phase_done;

  assign phase_done   = (state_i == STORING) && z_empty_i;
  assign store_step_o = phase_done;
  assign last_store_o = phase_done && (cnt_q == total_stores_i - job_cnt_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i || last_store_o || (state_i == IDLE) || (state_i == FINISHED)) begin
      cnt_q <= '0;
    end else if (phase_done) begin
      cnt_q <= cnt_q + job_cnt_t'(1);
    end
  end

  // Final phase always wraps the count before it passes the total
  a_cnt_bound : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (state_i != IDLE) |-> (cnt_q <= total_stores_i));

endmodule

//--- design/tile_ctrl_fsm.sv
// Job state machine of the control unit
// State register, transitions and the engine and scheduler controls

module tile_ctrl_fsm
  import mmctl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        job_start_i,
  input  logic        w_loaded_i,
  input  logic        reg_enable_i,
  input  logic        z_full_i,
  input  logic        w_tile_i,
  input  logic        tile_drained_i,
  input  logic        store_step_i,
  input  logic        last_store_i,
  output ctrl_state_e state_o,
  output logic        busy_o,
  output logic        done_o,
  output logic        w_shift_o,
  output logic        z_fill_o,
  output logic        flush_o,
  output logic        first_load_o,
  output logic        storing_o,
  output logic        finished_o,
  output logic        sched_rst_o,
  output logic        acc_set_o,
  output logic        acc_clr_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else if (clear_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (job_start_i) begin
          state_d = STARTING;
        end
      end
      // Wait for the first weight row
      STARTING: begin
        if (w_loaded_i) begin
          state_d = COMPUTING;
        end
      end
      COMPUTING: begin
        if (tile_drained_i) begin
          state_d = BUFFERING;
        end
      end
      BUFFERING: begin
        if (z_full_i) begin
          state_d = STORING;
        end
      end
      // Last phase ends the job, any other resumes computing
      STORING: begin
        if (last_store_i) begin
          state_d = FINISHED;
        end else if (store_step_i) begin
          state_d = COMPUTING;
        end
      end
      FINISHED: state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  assign state_o      = state_q;
  assign busy_o       = (state_q != IDLE) && (state_q != FINISHED);
  assign done_o       = (state_q == FINISHED);
  assign w_shift_o    = (state_q != IDLE) && (state_q != STARTING);
  assign z_fill_o     = (state_q == BUFFERING) && reg_enable_i;
  assign flush_o      = (state_q == FINISHED);
  assign first_load_o = (state_q == STARTING);
  assign storing_o    = (state_q == STORING);
  // Scheduler sees the end one cycle early on the final store
  assign finished_o   = (state_q == FINISHED) || ((state_q == STORING) && last_store_i);
  assign sched_rst_o  = (state_q == FINISHED);

  assign acc_set_o = ((state_q == COMPUTING) && w_tile_i) ||
                     ((state_q == BUFFERING) && z_full_i);
  assign acc_clr_o = ((state_q == COMPUTING) && tile_drained_i) ||
                     (state_q == FINISHED);

  // Buffer fill and store never overlap
  a_fill_store_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(z_fill_o && storing_o));

endmodule

//--- design/mmctl_top.sv
// Top level of the matrix-multiply control unit
// Register slave, job FSM, weight-row tracker,
// accumulate generator and store-phase counter

module mmctl_top
  import mmctl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      periph_req_i,
  input  bus_addr_t periph_add_i,
  input  logic      periph_wen_i,
  input  bus_data_t periph_data_i,
  output logic      periph_gnt_o,
  output bus_data_t periph_r_data_o,
  output logic      periph_r_valid_o,
  input  logic      w_loaded_i,
  input  logic      reg_enable_i,
  input  logic      z_full_i,
  input  logic      z_empty_i,
  output logic      busy_o,
  output logic      clear_o,
  output logic      done_evt_o,
  output logic      w_shift_o,
  output logic      z_fill_o,
  output logic      flush_o,
  output logic      accumulate_o,
  output logic      first_load_o,
  output logic      storing_o,
  output logic      finished_o,
  output logic      sched_rst_o
);

  logic        job_start;
  logic        clear;
  logic        busy;
  logic        done;
  job_cnt_t    rows_per_tile;
  job_cnt_t    total_stores;
  ctrl_state_e state;
  logic        w_tile;
  logic        tile_drained;
  logic        store_step;
  logic        last_store;
  logic        acc_set;
  logic        acc_clr;

  mmctl_regfile u_regfile (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .periph_req_i     (periph_req_i),
    .periph_add_i     (periph_add_i),
    .periph_wen_i     (periph_wen_i),
    .periph_data_i    (periph_data_i),
    .periph_gnt_o     (periph_gnt_o),
    .periph_r_data_o  (periph_r_data_o),
    .periph_r_valid_o (periph_r_valid_o),
    .busy_i           (busy),
    .done_i           (done),
    .job_start_o      (job_start),
    .clear_o          (clear),
    .rows_per_tile_o  (rows_per_tile),
    .total_stores_o   (total_stores),
    .done_evt_o       (done_evt_o)
  );

  tile_ctrl_fsm u_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear),
    .job_start_i    (job_start),
    .w_loaded_i     (w_loaded_i),
    .reg_enable_i   (reg_enable_i),
    .z_full_i       (z_full_i),
    .w_tile_i       (w_tile),
    .tile_drained_i (tile_drained),
    .store_step_i   (store_step),
    .last_store_i   (last_store),
    .state_o        (state),
    .busy_o         (busy),
    .done_o         (done),
    .w_shift_o      (w_shift_o),
    .z_fill_o       (z_fill_o),
    .flush_o        (flush_o),
    .first_load_o   (first_load_o),
    .storing_o      (storing_o),
    .finished_o     (finished_o),
    .sched_rst_o    (sched_rst_o),
    .acc_set_o      (acc_set),
    .acc_clr_o      (acc_clr)
  );

  weight_row_tracker u_tracker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clear_i         (clear),
    .state_i         (state),
    .w_loaded_i      (w_loaded_i),
    .reg_enable_i    (reg_enable_i),
    .rows_per_tile_i (rows_per_tile),
    .w_tile_o        (w_tile),
    .tile_drained_o  (tile_drained)
  );

  accumulate_gen u_acc (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear),
    .reg_enable_i (reg_enable_i),
    .set_i        (acc_set),
    .clr_i        (acc_clr),
    .accumulate_o (accumulate_o)
  );

  store_phase_counter u_stores (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear),
    .state_i        (state),
    .z_empty_i      (z_empty_i),
    .total_stores_i (total_stores),
    .store_step_o   (store_step),
    .last_store_o   (last_store)
  );

  assign busy_o  = busy;
  assign clear_o = clear;

endmodule

//--- sim/tb_mmctl_top.sv
// Testbench for the matrix-multiply control unit
// Clock and reset, peripheral bus tasks, engine and buffer model
// driven by xorshift stalls, and concurrent checking assertions

`include "mmctl_params.svh"

module tb_mmctl_top
  import mmctl_pkg::*;
;

  logic      clk_i;
  logic      rst_ni;
  logic      periph_req_i;
  bus_addr_t periph_add_i;
  logic      periph_wen_i;
  bus_data_t periph_data_i;
  logic      periph_gnt_o;
  bus_data_t periph_r_data_o;
  logic      periph_r_valid_o;
  logic      w_loaded_i;
  logic      reg_enable_i;
  logic      z_full_i;
  logic      z_empty_i;
  logic      busy_o;
  logic      clear_o;
  logic      done_evt_o;
  logic      w_shift_o;
  logic      z_fill_o;
  logic      flush_o;
  logic      accumulate_o;
  logic      first_load_o;
  logic      storing_o;
  logic      finished_o;
  logic      sched_rst_o;

  // Failures seen by the assertions, by the test sequence, and waits that ran out
  int value_errs = 0;
  int proto_errs = 0;
  int seq_errs = 0;
  int timeouts = 0;

  // Reference state derived from the register map
  job_cnt_t  rows_exp;
  job_cnt_t  stores_exp;
  bus_data_t rd_exp;
  job_cnt_t  store_rises;
  logic      storing_q;
  logic      job_cleared;
  int        done_pulses;

  logic wr_grant;
  logic rd_grant;
  logic trig_grant;
  logic clr_grant;

  mmctl_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [9:0] ctrl_outputs();
    return {busy_o, z_fill_o, w_shift_o, flush_o, accumulate_o,
            first_load_o, storing_o, finished_o, sched_rst_o, done_evt_o};
  endfunction

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    value_errs++;
    $display("Fail %s expected %h actual %h", name, exp, act);
  endtask

  task automatic protocol_error(input string msg);
    proto_errs++;
    $display("Protocol error: %s", msg);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    seq_errs++;
    $display("Fail %s expected %h actual %h", name, exp, act);
  endtask

  task automatic timeout_seen(input string what);
    timeouts++;
    $display("Timeout: no %s within the wait limit", what);
  endtask

  // Engine, output buffer and scheduler as seen by the control unit
  initial begin : engine_model
    logic [31:0] rnd;
    logic [1:0]  load_div;
    int          fill_cyc;
    int          store_cyc;
    logic        busy_s;
    logic        fill_s;
    logic        store_s;
    logic        full_s;
    logic        empty_s;
    rnd          = 32'he94b;
    load_div     = 2'd0;
    fill_cyc     = 0;
    store_cyc    = 0;
    w_loaded_i   = 1'b0;
    reg_enable_i = 1'b1;
    z_full_i     = 1'b0;
    z_empty_i    = 1'b0;
    forever begin
      // Sample the settled values of the current cycle
      @(negedge clk_i);
      busy_s  = busy_o;
      fill_s  = z_fill_o;
      store_s = storing_o;
      full_s  = z_full_i;
      empty_s = z_empty_i;
      @(posedge clk_i);
      #1;
      rnd      = next_rand(rnd);
      load_div = load_div + 2'd1;
      if (!busy_s || store_s) begin
        fill_cyc = 0;
      end else if (fill_s && !full_s) begin
        fill_cyc++;
      end
      if (store_s && !empty_s) begin
        store_cyc++;
      end else begin
        store_cyc = 0;
      end
      // One weight row every four cycles while a job runs
      w_loaded_i   = busy_s && (load_div == 2'd0);
      reg_enable_i = (rnd[1:0] != 2'b00);
      z_full_i     = !full_s && (fill_cyc >= 3);
      z_empty_i    = (store_cyc == 3);
    end
  end

  assign wr_grant   = periph_req_i && periph_gnt_o && !periph_wen_i;
  assign rd_grant   = periph_req_i && periph_gnt_o && periph_wen_i;
  assign trig_grant = wr_grant && (periph_add_i == `MMCTL_REG_TRIGGER);
  assign clr_grant  = wr_grant && (periph_add_i == `MMCTL_REG_CLEAR);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rows_exp    <= '0;
      stores_exp  <= '0;
      rd_exp      <= '0;
      store_rises <= '0;
      storing_q   <= 1'b0;
      job_cleared <= 1'b0;
      done_pulses <= 0;
    end else begin
      if (wr_grant && (periph_add_i == `MMCTL_REG_ROWS)) begin
        rows_exp <= periph_data_i[`MMCTL_CNT_W-1:0];
      end
      if (wr_grant && (periph_add_i == `MMCTL_REG_STORES)) begin
        stores_exp <= periph_data_i[`MMCTL_CNT_W-1:0];
      end
      if (rd_grant) begin
        case (periph_add_i)
          `MMCTL_REG_STATUS: rd_exp <= {31'b0, busy_o};
          `MMCTL_REG_ROWS:   rd_exp <= bus_data_t'(rows_exp);
          `MMCTL_REG_STORES: rd_exp <= bus_data_t'(stores_exp);
          default:           rd_exp <= '0;
        endcase
      end
      if (trig_grant) begin
        store_rises <= '0;
        job_cleared <= 1'b0;
      end else if (storing_o && !storing_q) begin
        store_rises <= store_rises + job_cnt_t'(1);
      end
      if (clr_grant) begin
        job_cleared <= 1'b1;
      end
      storing_q <= storing_o;
      if (done_evt_o) begin
        done_pulses <= done_pulses + 1;
      end
    end
  end

  // Register port
  a_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    periph_gnt_o == periph_req_i)
    else protocol_error("grant differs from request");
  a_rvalid_follows : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_grant |=> periph_r_valid_o)
    else protocol_error("read data valid missing one cycle after a read grant");
  a_rvalid_only : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rd_grant |=> !periph_r_valid_o)
    else protocol_error("read data valid without a read grant");
  a_rdata : assert property (@(posedge clk_i) disable iff (!rst_ni)
    periph_r_valid_o |-> periph_r_data_o == rd_exp)
    else value_error("periph_r_data_o", $sampled(rd_exp), $sampled(periph_r_data_o));

  // Job start
  a_busy_rise : assert property (@(posedge clk_i) disable iff (!rst_ni)
    trig_grant && !busy_o && !clear_o |=> !busy_o ##1 busy_o)
    else protocol_error("busy did not rise two cycles after the trigger");
  a_first_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    first_load_o && !w_loaded_i && !clear_o |=> first_load_o)
    else protocol_error("first load dropped before a weight row arrived");
  a_first_end : assert property (@(posedge clk_i) disable iff (!rst_ni)
    first_load_o && w_loaded_i && !clear_o |=> !first_load_o && w_shift_o)
    else protocol_error("first load did not end on the first weight row");
  a_shift_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    first_load_o |-> !w_shift_o)
    else protocol_error("weight shift during the first load");
  a_fill_window : assert property (@(posedge clk_i) disable iff (!rst_ni)
    z_fill_o |-> !storing_o && busy_o && reg_enable_i)
    else protocol_error("buffer fill outside the buffering window");

  // Job end
  a_finish_cycle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_o |-> sched_rst_o && finished_o && !busy_o)
    else protocol_error("flush without scheduler reset and finish or while busy");
  a_finish_once : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_o |=> !flush_o && !sched_rst_o && !busy_o && !accumulate_o && done_evt_o)
    else protocol_error("finish lasted more than one cycle or raised no done event");
  a_done_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_evt_o |=> !done_evt_o)
    else protocol_error("done event longer than one cycle");
  a_store_count : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_o |-> store_rises == stores_exp)
    else value_error("storing_o rises", 32'($sampled(stores_exp)),
                     32'($sampled(store_rises)));

  // Soft clear
  a_clear_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    clr_grant |=> clear_o)
    else protocol_error("no clear pulse after a clear write");
  a_clear_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    clr_grant |-> ##2 !busy_o)
    else protocol_error("busy still high two cycles after a clear");
  a_no_done_cleared : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_evt_o |-> !job_cleared)
    else protocol_error("done event for a cleared job");

  task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
    @(posedge clk_i);
    #1;
    periph_req_i  = 1'b1;
    periph_wen_i  = 1'b0;
    periph_add_i  = addr;
    periph_data_i = data;
    @(posedge clk_i);
    #1;
    periph_req_i = 1'b0;
    periph_wen_i = 1'b1;
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_data_t data, output logic ok);
    int n;
    @(posedge clk_i);
    #1;
    periph_req_i = 1'b1;
    periph_wen_i = 1'b1;
    periph_add_i = addr;
    @(posedge clk_i);
    #1;
    periph_req_i = 1'b0;
    n = 0;
    while (!periph_r_valid_o && n < 4) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    ok   = periph_r_valid_o;
    data = periph_r_data_o;
    if (!ok) timeout_seen("read data valid");
  endtask

  task automatic wait_store_phase(input int limit, output logic ok);
    int n;
    n = 0;
    while (!storing_o && n < limit) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    ok = storing_o;
    if (!ok) timeout_seen("store phase");
  endtask

  task automatic wait_job_done(input int limit, output logic ok);
    int n;
    n = 0;
    while (!done_evt_o && n < limit) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    ok = done_evt_o;
    if (!ok) timeout_seen("done event");
  endtask

  task automatic check_outputs_low();
    assert (ctrl_outputs() == '0)
      else report_mismatch("control outputs", 32'h0, 32'(ctrl_outputs()));
  endtask

  task automatic check_status_idle();
    bus_data_t rd;
    logic      ok;
    bus_read(`MMCTL_REG_STATUS, rd, ok);
    if (ok) begin
      assert (rd[0] == 1'b0)
        else report_mismatch("periph_r_data_o", 32'h0, rd);
    end
  endtask

  task automatic run_test();
    bus_data_t rd;
    logic      ok;
    check_outputs_low();
    // Upper halves must not reach the parameter registers
    bus_write(`MMCTL_REG_ROWS, 32'hbeef_0006);
    bus_write(`MMCTL_REG_STORES, 32'h5a5a_0003);
    bus_read(`MMCTL_REG_ROWS, rd, ok);
    if (!ok) return;
    bus_read(`MMCTL_REG_STORES, rd, ok);
    if (!ok) return;
    check_status_idle();

    // First job is cut short by a clear during its first store phase
    bus_write(`MMCTL_REG_TRIGGER, 32'h1);
    wait_store_phase(1500, ok);
    if (!ok) return;
    bus_write(`MMCTL_REG_CLEAR, 32'h1);
    @(posedge clk_i);
    #1;
    check_outputs_low();
    check_status_idle();

    // Second job runs to completion with three store phases
    bus_write(`MMCTL_REG_ROWS, 32'h0000_0004);
    bus_write(`MMCTL_REG_TRIGGER, 32'h1);
    wait_job_done(4000, ok);
    if (!ok) return;
    check_status_idle();
    check_outputs_low();
    assert (done_pulses == 1)
      else report_mismatch("done_evt_o pulses", 32'h1, 32'(done_pulses));
  endtask

  initial begin
    rst_ni        = 1'b0;
    periph_req_i  = 1'b0;
    periph_add_i  = '0;
    periph_wen_i  = 1'b1;
    periph_data_i = '0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    run_test();
    repeat (5) @(posedge clk_i);
    $display("Errors: %0d assertion value, %0d protocol, %0d sequence, %0d timeout",
             value_errs, proto_errs, seq_errs, timeouts);
    if (value_errs + proto_errs + seq_errs + timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- mmctl_top.f
+incdir+design
design/mmctl_pkg.sv
design/mmctl_regfile.sv
design/weight_row_tracker.sv
design/accumulate_gen.sv
design/store_phase_counter.sv
design/tile_ctrl_fsm.sv
design/mmctl_top.sv
sim/tb_mmctl_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_mmctl_top \
  -f mmctl_top.f --Mdir "$BUILD_DIR" -o Vtb_mmctl_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_mmctl_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
